// File: ao_bus_pkg.sv
// ----------------------------------------
// Register bus widths and word types
// Accesses are whole 32-bit words only
// ----------------------------------------

package ao_bus_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Word offset inside one peripheral, address bits 3:2
  localparam int unsigned REG_OFS_LSB = 2;
  localparam int unsigned REG_OFS_W   = 2;

endpackage : ao_bus_pkg

// File: ao_periph_pkg.sv
// ----------------------------------------
// Peripheral map on address bits 9:8
// Other address bits are not decoded
// ----------------------------------------

package ao_periph_pkg;

  localparam int unsigned PERIPH_SEL_LSB = 8;
  localparam int unsigned PERIPH_SEL_W   = 2;

  typedef enum logic [PERIPH_SEL_W-1:0] {
    SOC_CTRL  = 2'd0,
    FAST_INTR = 2'd1,
    GPIO      = 2'd2,
    UNMAPPED  = 2'd3
  } periph_sel_e;

  // SoC control word offsets
  localparam logic [1:0] EXIT_VALID_OFS  = 2'd0;
  localparam logic [1:0] EXIT_VALUE_OFS  = 2'd1;
  localparam logic [1:0] BOOT_SEL_OFS    = 2'd2;
  localparam logic [1:0] INSTANCE_ID_OFS = 2'd3;

  // Fast interrupt word offsets
  localparam logic [1:0] FI_PENDING_OFS = 2'd0;
  localparam logic [1:0] FI_ENABLE_OFS  = 2'd1;

  // GPIO word offsets
  localparam logic [1:0] GPIO_IN_OFS      = 2'd0;
  localparam logic [1:0] GPIO_OUT_OFS     = 2'd1;
  localparam logic [1:0] GPIO_EN_OFS      = 2'd2;
  localparam logic [1:0] GPIO_INTR_EN_OFS = 2'd3;

  localparam int unsigned NUM_FAST_INTR = 16;
  localparam int unsigned GPIO_W        = 8;

endpackage : ao_periph_pkg

// File: ao_reg_bus_if.sv
// ----------------------------------------
// Wishbone classic, one word per access
// Device answers with one-cycle ack or err
// ----------------------------------------

`timescale 1ns/1ps

interface ao_reg_bus_if
  import ao_bus_pkg::*;
();

  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;
  data_t dat_w;
  data_t dat_r;
  logic  ack;
  logic  err;

  modport host (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack, err
  );

  modport device (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack, err
  );

endinterface : ao_reg_bus_if

// File: ao_bus_arbiter.sv
// ----------------------------------------
// Round-robin arbiter for one access at a time
// Grant lands one cycle after the request
// ----------------------------------------

`timescale 1ns/1ps

module ao_bus_arbiter
  import ao_bus_pkg::*;
#(
  parameter int unsigned NUM_REQ = 2
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic  [NUM_REQ-1:0] req_cyc_i,
  input  logic  [NUM_REQ-1:0] req_stb_i,
  input  logic  [NUM_REQ-1:0] req_we_i,
  input  addr_t [NUM_REQ-1:0] req_adr_i,
  input  data_t [NUM_REQ-1:0] req_dat_i,
  output data_t [NUM_REQ-1:0] req_dat_o,
  output logic  [NUM_REQ-1:0] req_ack_o,
  output logic  [NUM_REQ-1:0] req_err_o,
  ao_reg_bus_if.host          bus_o
);

  localparam int unsigned IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  logic [NUM_REQ-1:0] req_valid;
  logic [NUM_REQ-1:0] granted;
  logic               busy_q;
  logic [IDX_W-1:0]   gnt_q;
  logic [IDX_W-1:0]   last_q;
  logic [IDX_W-1:0]   next_idx;
  logic               done;

  assign req_valid = req_cyc_i & req_stb_i;
  assign done      = bus_o.ack || bus_o.err;

  // Walk down so the first requester after last_q wins
  always_comb begin
    int cand;
    next_idx = last_q;
    for (int i = NUM_REQ; i >= 1; i--) begin
      cand = (int'(last_q) + i) % NUM_REQ;
      if (req_valid[cand]) begin
        next_idx = IDX_W'(cand);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      gnt_q  <= '0;
      last_q <= IDX_W'(NUM_REQ - 1);
    end else if (!busy_q) begin
      if (|req_valid) begin
        busy_q <= 1'b1;
        gnt_q  <= next_idx;
      end
    end else if (done) begin
      busy_q <= 1'b0;
      last_q <= gnt_q;
    end
  end

  // Granted request straight onto the shared bus
  assign bus_o.cyc   = busy_q && req_cyc_i[gnt_q];
  assign bus_o.stb   = busy_q && req_stb_i[gnt_q];
  assign bus_o.we    = req_we_i[gnt_q];
  assign bus_o.adr   = req_adr_i[gnt_q];
  assign bus_o.dat_w = req_dat_i[gnt_q];

  for (genvar g = 0; g < NUM_REQ; g++) begin : gen_rsp
    assign granted[g]   = busy_q && (gnt_q == IDX_W'(g));
    assign req_ack_o[g] = granted[g] && bus_o.ack;
    assign req_err_o[g] = granted[g] && bus_o.err;
    assign req_dat_o[g] = granted[g] ? bus_o.dat_r : '0;
  end

  // Responses only while a grant is held
  assert property (@(posedge clk_i) disable iff (rst_i)
    done |-> busy_q);

  // Granted request held steady until the response
  assert property (@(posedge clk_i) disable iff (rst_i)
    (busy_q && !done) |=> $stable(gnt_q) && $stable(bus_o.adr) &&
                          $stable(bus_o.we) && $stable(bus_o.dat_w));

endmodule : ao_bus_arbiter

// File: ao_periph_decoder.sv
// ----------------------------------------
// Routes by address bits 9:8
// Unmapped field answers err one cycle late
// ----------------------------------------

`timescale 1ns/1ps

module ao_periph_decoder
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  ao_reg_bus_if.device bus_i,
  ao_reg_bus_if.host   soc_o,
  ao_reg_bus_if.host   fi_o,
  ao_reg_bus_if.host   gpio_o
);

  periph_sel_e sel;
  logic        err_q;

  assign sel = periph_sel_e'(bus_i.adr[PERIPH_SEL_LSB +: PERIPH_SEL_W]);

  // Everything but stb fans out to all peripherals
  assign soc_o.cyc    = bus_i.cyc;
  assign soc_o.stb    = bus_i.stb && (sel == SOC_CTRL);
  assign soc_o.we     = bus_i.we;
  assign soc_o.adr    = bus_i.adr;
  assign soc_o.dat_w  = bus_i.dat_w;

  assign fi_o.cyc     = bus_i.cyc;
  assign fi_o.stb     = bus_i.stb && (sel == FAST_INTR);
  assign fi_o.we      = bus_i.we;
  assign fi_o.adr     = bus_i.adr;
  assign fi_o.dat_w   = bus_i.dat_w;

  assign gpio_o.cyc   = bus_i.cyc;
  assign gpio_o.stb   = bus_i.stb && (sel == GPIO);
  assign gpio_o.we    = bus_i.we;
  assign gpio_o.adr   = bus_i.adr;
  assign gpio_o.dat_w = bus_i.dat_w;

  // One-cycle err pulse for the hole in the map
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_i.cyc && bus_i.stb && (sel == UNMAPPED) && !err_q;
    end
  end

  always_comb begin
    bus_i.dat_r = '0;
    bus_i.ack   = 1'b0;
    bus_i.err   = err_q;
    case (sel)
      SOC_CTRL: begin
        bus_i.dat_r = soc_o.dat_r;
        bus_i.ack   = soc_o.ack;
        bus_i.err   = soc_o.err;
      end
      FAST_INTR: begin
        bus_i.dat_r = fi_o.dat_r;
        bus_i.ack   = fi_o.ack;
        bus_i.err   = fi_o.err;
      end
      GPIO: begin
        bus_i.dat_r = gpio_o.dat_r;
        bus_i.ack   = gpio_o.ack;
        bus_i.err   = gpio_o.err;
      end
      default: ;
    endcase
  end

  assert property (@(posedge clk_i) disable iff (rst_i) !(bus_i.ack && bus_i.err));

endmodule : ao_periph_decoder

// File: ao_soc_ctrl.sv
// ----------------------------------------
// Exit status, boot select and instance id
// ----------------------------------------

`timescale 1ns/1ps

module ao_soc_ctrl
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  ao_reg_bus_if.device bus_i,
  input  data_t        xheep_instance_id_i,
  input  logic         boot_select_i,
  output logic         exit_valid_o,
  output data_t        exit_value_o
);

  logic                 ack_q;
  logic                 access;
  logic [REG_OFS_W-1:0] ofs;
  data_t                rdata;
  data_t                rdata_q;

  assign access = bus_i.cyc && bus_i.stb && !ack_q;
  assign ofs    = bus_i.adr[REG_OFS_LSB +: REG_OFS_W];

  always_comb begin
    case (ofs)
      EXIT_VALID_OFS:  rdata = data_t'(exit_valid_o);
      EXIT_VALUE_OFS:  rdata = exit_value_o;
      BOOT_SEL_OFS:    rdata = data_t'(boot_select_i);
      INSTANCE_ID_OFS: rdata = xheep_instance_id_i;
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q        <= 1'b0;
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else begin
      ack_q <= access;
      if (access && bus_i.we && ofs == EXIT_VALID_OFS) begin
        exit_valid_o <= bus_i.dat_w[0];
      end
      if (access && bus_i.we && ofs == EXIT_VALUE_OFS) begin
        exit_value_o <= bus_i.dat_w;
      end
    end
  end

  // Read word captured with the ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata;
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.err   = 1'b0;
  assign bus_i.dat_r = rdata_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
    bus_i.ack |-> $past(bus_i.cyc && bus_i.stb));

endmodule : ao_soc_ctrl

// File: ao_fast_intr_ctrl.sv
// ----------------------------------------
// Level inputs latch into pending bits
// A high input wins over a clear
// ----------------------------------------

`timescale 1ns/1ps

module ao_fast_intr_ctrl
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  ao_reg_bus_if.device             bus_i,
  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o
);

  logic                     ack_q;
  logic                     access;
  logic [REG_OFS_W-1:0]     ofs;
  logic [NUM_FAST_INTR-1:0] pending_q;
  logic [NUM_FAST_INTR-1:0] enable_q;
  logic [NUM_FAST_INTR-1:0] clr;
  data_t                    rdata_q;

  assign access = bus_i.cyc && bus_i.stb && !ack_q;
  assign ofs    = bus_i.adr[REG_OFS_LSB +: REG_OFS_W];

  // Write-one-to-clear mask
  assign clr = (access && bus_i.we && ofs == FI_PENDING_OFS) ?
               bus_i.dat_w[NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q     <= 1'b0;
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      ack_q     <= access;
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (access && bus_i.we && ofs == FI_ENABLE_OFS) begin
        enable_q <= bus_i.dat_w[NUM_FAST_INTR-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      case (ofs)
        FI_PENDING_OFS: rdata_q <= data_t'(pending_q);
        FI_ENABLE_OFS:  rdata_q <= data_t'(enable_q);
        default:        rdata_q <= '0;
      endcase
    end
  end

  assign fast_intr_o = pending_q & enable_q;

  assign bus_i.ack   = ack_q;
  assign bus_i.err   = 1'b0;
  assign bus_i.dat_r = rdata_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
    bus_i.ack |-> $past(bus_i.cyc && bus_i.stb));

endmodule : ao_fast_intr_ctrl

// File: ao_gpio.sv
// ----------------------------------------
// 8-bit GPIO, inputs pass two sync flops
// Level interrupt, no edge detection
// ----------------------------------------

`timescale 1ns/1ps

module ao_gpio
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  ao_reg_bus_if.device      bus_i,
  input  logic [GPIO_W-1:0] cio_gpio_i,
  output logic [GPIO_W-1:0] cio_gpio_o,
  output logic [GPIO_W-1:0] cio_gpio_en_o,
  output logic [GPIO_W-1:0] intr_gpio_o
);

  logic                 ack_q;
  logic                 access;
  logic                 wr_en;
  logic [REG_OFS_W-1:0] ofs;
  logic [GPIO_W-1:0]    sync_q1;
  logic [GPIO_W-1:0]    sync_q2;
  logic [GPIO_W-1:0]    intr_en_q;
  data_t                rdata_q;

  assign access = bus_i.cyc && bus_i.stb && !ack_q;
  assign wr_en  = access && bus_i.we;
  assign ofs    = bus_i.adr[REG_OFS_LSB +: REG_OFS_W];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q         <= 1'b0;
      sync_q1       <= '0;
      sync_q2       <= '0;
      cio_gpio_o    <= '0;
      cio_gpio_en_o <= '0;
      intr_en_q     <= '0;
    end else begin
      ack_q   <= access;
      sync_q1 <= cio_gpio_i;
      sync_q2 <= sync_q1;
      if (wr_en && ofs == GPIO_OUT_OFS) begin
        cio_gpio_o <= bus_i.dat_w[GPIO_W-1:0];
      end
      if (wr_en && ofs == GPIO_EN_OFS) begin
        cio_gpio_en_o <= bus_i.dat_w[GPIO_W-1:0];
      end
      if (wr_en && ofs == GPIO_INTR_EN_OFS) begin
        intr_en_q <= bus_i.dat_w[GPIO_W-1:0];
      end
    end
  end

  // GPIO_IN is read-only, writes to it are dropped
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (ofs)
        GPIO_IN_OFS:      rdata_q <= data_t'(sync_q2);
        GPIO_OUT_OFS:     rdata_q <= data_t'(cio_gpio_o);
        GPIO_EN_OFS:      rdata_q <= data_t'(cio_gpio_en_o);
        GPIO_INTR_EN_OFS: rdata_q <= data_t'(intr_en_q);
        default:          rdata_q <= '0;
      endcase
    end
  end

  assign intr_gpio_o = sync_q2 & intr_en_q;

  assign bus_i.ack   = ack_q;
  assign bus_i.err   = 1'b0;
  assign bus_i.dat_r = rdata_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
    bus_i.ack |-> $past(bus_i.cyc && bus_i.stb));

endmodule : ao_gpio

// File: ao_peripheral_subsystem.sv
// ----------------------------------------
// System port is requester 0, SPC ports 1+
// Uncontended ack or err after 2 cycles
// ----------------------------------------

`timescale 1ns/1ps

module ao_peripheral_subsystem
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
#(
  parameter int unsigned NUM_SPC = 1
) (
  input  logic                     clk_i,
  input  logic                     rst_i,

  // System bus port
  input  logic                     sys_cyc_i,
  input  logic                     sys_stb_i,
  input  logic                     sys_we_i,
  input  addr_t                    sys_adr_i,
  input  data_t                    sys_dat_i,
  output data_t                    sys_dat_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,

  // Co-processor ports
  input  logic  [NUM_SPC-1:0]      spc_cyc_i,
  input  logic  [NUM_SPC-1:0]      spc_stb_i,
  input  logic  [NUM_SPC-1:0]      spc_we_i,
  input  addr_t [NUM_SPC-1:0]      spc_adr_i,
  input  data_t [NUM_SPC-1:0]      spc_dat_i,
  output data_t [NUM_SPC-1:0]      spc_dat_o,
  output logic  [NUM_SPC-1:0]      spc_ack_o,
  output logic  [NUM_SPC-1:0]      spc_err_o,

  // SoC control
  input  data_t                    xheep_instance_id_i,
  input  logic                     boot_select_i,
  output logic                     exit_valid_o,
  output data_t                    exit_value_o,

  // Fast interrupts
  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o,

  // GPIO
  input  logic [GPIO_W-1:0]        cio_gpio_i,
  output logic [GPIO_W-1:0]        cio_gpio_o,
  output logic [GPIO_W-1:0]        cio_gpio_en_o,
  output logic [GPIO_W-1:0]        intr_gpio_o
);

  localparam int unsigned NUM_REQ = NUM_SPC + 1;

  data_t [NUM_REQ-1:0] req_dat_o;
  logic  [NUM_REQ-1:0] req_ack_o;
  logic  [NUM_REQ-1:0] req_err_o;

  ao_reg_bus_if arb_bus  ();
  ao_reg_bus_if soc_bus  ();
  ao_reg_bus_if fi_bus   ();
  ao_reg_bus_if gpio_bus ();

  // Responses split back to the system and SPC ports
  assign sys_dat_o = req_dat_o[0];
  assign sys_ack_o = req_ack_o[0];
  assign sys_err_o = req_err_o[0];
  assign spc_dat_o = req_dat_o[NUM_REQ-1:1];
  assign spc_ack_o = req_ack_o[NUM_REQ-1:1];
  assign spc_err_o = req_err_o[NUM_REQ-1:1];

  ao_bus_arbiter #(
    .NUM_REQ (NUM_REQ)
  ) i_ao_bus_arbiter (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_cyc_i ({spc_cyc_i, sys_cyc_i}),
    .req_stb_i ({spc_stb_i, sys_stb_i}),
    .req_we_i  ({spc_we_i, sys_we_i}),
    .req_adr_i ({spc_adr_i, sys_adr_i}),
    .req_dat_i ({spc_dat_i, sys_dat_i}),
    .req_dat_o (req_dat_o),
    .req_ack_o (req_ack_o),
    .req_err_o (req_err_o),
    .bus_o     (arb_bus)
  );

  ao_periph_decoder i_ao_periph_decoder (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .bus_i  (arb_bus),
    .soc_o  (soc_bus),
    .fi_o   (fi_bus),
    .gpio_o (gpio_bus)
  );

  ao_soc_ctrl i_ao_soc_ctrl (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .bus_i               (soc_bus),
    .xheep_instance_id_i (xheep_instance_id_i),
    .boot_select_i       (boot_select_i),
    .exit_valid_o        (exit_valid_o),
    .exit_value_o        (exit_value_o)
  );

  ao_fast_intr_ctrl i_ao_fast_intr_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_i       (fi_bus),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  ao_gpio i_ao_gpio (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .bus_i         (gpio_bus),
    .cio_gpio_i    (cio_gpio_i),
    .cio_gpio_o    (cio_gpio_o),
    .cio_gpio_en_o (cio_gpio_en_o),
    .intr_gpio_o   (intr_gpio_o)
  );

endmodule : ao_peripheral_subsystem

// File: tb_ao_peripheral_subsystem.sv
// ----------------------------------------
// Self-checking testbench, NUM_SPC = 1
// Stops at the first mismatch
// ----------------------------------------

`timescale 1ns/1ps

module tb_ao_peripheral_subsystem
  import ao_bus_pkg::*;
  import ao_periph_pkg::*;
();

  localparam int unsigned NUM_SPC        = 1;
  localparam int unsigned STREAM_LEN     = 40;
  localparam int          TIMEOUT_CYCLES = 200 * 20;

  logic                     clk_i;
  logic                     rst_i;
  logic                     sys_cyc_i;
  logic                     sys_stb_i;
  logic                     sys_we_i;
  addr_t                    sys_adr_i;
  data_t                    sys_dat_i;
  data_t                    sys_dat_o;
  logic                     sys_ack_o;
  logic                     sys_err_o;
  logic  [NUM_SPC-1:0]      spc_cyc_i;
  logic  [NUM_SPC-1:0]      spc_stb_i;
  logic  [NUM_SPC-1:0]      spc_we_i;
  addr_t [NUM_SPC-1:0]      spc_adr_i;
  data_t [NUM_SPC-1:0]      spc_dat_i;
  data_t [NUM_SPC-1:0]      spc_dat_o;
  logic  [NUM_SPC-1:0]      spc_ack_o;
  logic  [NUM_SPC-1:0]      spc_err_o;
  data_t                    xheep_instance_id_i;
  logic                     boot_select_i;
  logic                     exit_valid_o;
  data_t                    exit_value_o;
  logic [NUM_FAST_INTR-1:0] fast_intr_i;
  logic [NUM_FAST_INTR-1:0] fast_intr_o;
  logic [GPIO_W-1:0]        cio_gpio_i;
  logic [GPIO_W-1:0]        cio_gpio_o;
  logic [GPIO_W-1:0]        cio_gpio_en_o;
  logic [GPIO_W-1:0]        intr_gpio_o;

  // Shadow copy of the register state
  logic                     sh_exit_valid;
  data_t                    sh_exit_value;
  logic [NUM_FAST_INTR-1:0] sh_fi_pending;
  logic [NUM_FAST_INTR-1:0] sh_fi_enable;
  logic [GPIO_W-1:0]        sh_gpio_out;
  logic [GPIO_W-1:0]        sh_gpio_en;
  logic [GPIO_W-1:0]        sh_gpio_intr_en;

  // Completed checks, {ack, err, data}
  string       name_q[$];
  logic [33:0] exp_q[$];
  logic [33:0] act_q[$];
  int          done_q[$];
  string       cur_name;
  logic [33:0] cur_exp;
  logic [33:0] cur_act;
  int          cycle_cnt;
  data_t       wdat;

  // Pre-drawn streams for the contention test
  addr_t st_adr [2][STREAM_LEN];
  data_t st_dat [2][STREAM_LEN];
  logic  st_we  [2][STREAM_LEN];

  ao_peripheral_subsystem #(
    .NUM_SPC (NUM_SPC)
  ) i_ao_peripheral_subsystem (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .sys_cyc_i           (sys_cyc_i),
    .sys_stb_i           (sys_stb_i),
    .sys_we_i            (sys_we_i),
    .sys_adr_i           (sys_adr_i),
    .sys_dat_i           (sys_dat_i),
    .sys_dat_o           (sys_dat_o),
    .sys_ack_o           (sys_ack_o),
    .sys_err_o           (sys_err_o),
    .spc_cyc_i           (spc_cyc_i),
    .spc_stb_i           (spc_stb_i),
    .spc_we_i            (spc_we_i),
    .spc_adr_i           (spc_adr_i),
    .spc_dat_i           (spc_dat_i),
    .spc_dat_o           (spc_dat_o),
    .spc_ack_o           (spc_ack_o),
    .spc_err_o           (spc_err_o),
    .xheep_instance_id_i (xheep_instance_id_i),
    .boot_select_i       (boot_select_i),
    .exit_valid_o        (exit_valid_o),
    .exit_value_o        (exit_value_o),
    .fast_intr_i         (fast_intr_i),
    .fast_intr_o         (fast_intr_o),
    .cio_gpio_i          (cio_gpio_i),
    .cio_gpio_o          (cio_gpio_o),
    .cio_gpio_en_o       (cio_gpio_en_o),
    .intr_gpio_o         (intr_gpio_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Random upper bits, only 9:8 and 3:2 select the register
  function automatic addr_t reg_addr(input logic [1:0] sel, input logic [1:0] ofs);
    addr_t a;
    a = addr_t'($urandom());
    a[PERIPH_SEL_LSB +: PERIPH_SEL_W] = sel;
    a[REG_OFS_LSB +: REG_OFS_W]       = ofs;
    a[1:0]                            = 2'b00;
    return a;
  endfunction

  // Expected {ack, err, data}, data zero on writes
  function automatic logic [33:0] ref_access(input addr_t adr, input logic we);
    periph_sel_e sel;
    logic [1:0]  ofs;
    data_t       d;
    sel = periph_sel_e'(adr[PERIPH_SEL_LSB +: PERIPH_SEL_W]);
    ofs = adr[REG_OFS_LSB +: REG_OFS_W];
    d   = '0;
    case (sel)
      SOC_CTRL: begin
        case (ofs)
          EXIT_VALID_OFS: d = {31'b0, sh_exit_valid};
          EXIT_VALUE_OFS: d = sh_exit_value;
          BOOT_SEL_OFS:   d = {31'b0, boot_select_i};
          default:        d = xheep_instance_id_i;
        endcase
      end
      FAST_INTR: begin
        case (ofs)
          FI_PENDING_OFS: d = {16'b0, sh_fi_pending};
          FI_ENABLE_OFS:  d = {16'b0, sh_fi_enable};
          default:        d = '0;
        endcase
      end
      GPIO: begin
        case (ofs)
          GPIO_IN_OFS:  d = {24'b0, cio_gpio_i};
          GPIO_OUT_OFS: d = {24'b0, sh_gpio_out};
          GPIO_EN_OFS:  d = {24'b0, sh_gpio_en};
          default:      d = {24'b0, sh_gpio_intr_en};
        endcase
      end
      default: return {2'b01, 32'h0};
    endcase
    if (we) begin
      d = '0;
    end
    return {2'b10, d};
  endfunction

  task automatic apply_write(input addr_t adr, input data_t d);
    periph_sel_e sel;
    logic [1:0]  ofs;
    sel = periph_sel_e'(adr[PERIPH_SEL_LSB +: PERIPH_SEL_W]);
    ofs = adr[REG_OFS_LSB +: REG_OFS_W];
    if (sel == SOC_CTRL && ofs == EXIT_VALID_OFS) sh_exit_valid = d[0];
    if (sel == SOC_CTRL && ofs == EXIT_VALUE_OFS) sh_exit_value = d;
    if (sel == FAST_INTR && ofs == FI_PENDING_OFS) sh_fi_pending &= ~d[15:0];
    if (sel == FAST_INTR && ofs == FI_ENABLE_OFS) sh_fi_enable = d[15:0];
    if (sel == GPIO && ofs == GPIO_OUT_OFS) sh_gpio_out = d[7:0];
    if (sel == GPIO && ofs == GPIO_EN_OFS) sh_gpio_en = d[7:0];
    if (sel == GPIO && ofs == GPIO_INTR_EN_OFS) sh_gpio_intr_en = d[7:0];
  endtask

  task automatic check_value(input string name, input logic [33:0] exp_val,
                             input logic [33:0] act_val);
    name_q.push_back(name);
    exp_q.push_back(exp_val);
    act_q.push_back(act_val);
  endtask

  task automatic drive_req(input int port, input logic stb, input logic we,
                           input addr_t adr, input data_t dat);
    if (port == 0) begin
      sys_cyc_i = stb;
      sys_stb_i = stb;
      sys_we_i  = we;
      sys_adr_i = adr;
      sys_dat_i = dat;
    end else begin
      spc_cyc_i[0] = stb;
      spc_stb_i[0] = stb;
      spc_we_i[0]  = we;
      spc_adr_i[0] = adr;
      spc_dat_i[0] = dat;
    end
  endtask

  function automatic logic [33:0] port_rsp(input int port);
    if (port == 0) begin
      return {sys_ack_o, sys_err_o, sys_dat_o};
    end
    return {spc_ack_o[0], spc_err_o[0], spc_dat_o[0]};
  endfunction

  // One classic access; address and data stay put while stb drops
  task automatic bus_access(input int port, input string name, input logic we,
                            input addr_t adr, input data_t wdata);
    logic [33:0] rsp;
    logic [33:0] exp_val;
    @(negedge clk_i);
    drive_req(port, 1'b1, we, adr, wdata);
    do begin
      @(negedge clk_i);
      rsp = port_rsp(port);
    end while (rsp[33:32] == 2'b00);
    drive_req(port, 1'b0, we, adr, wdata);
    exp_val = ref_access(adr, we);
    if (we) begin
      rsp[31:0] = '0;
      apply_write(adr, wdata);
    end
    check_value(name, exp_val, rsp);
    done_q.push_back(port);
  endtask

  task automatic pulse_fast_intr(input logic [NUM_FAST_INTR-1:0] v);
    @(negedge clk_i);
    fast_intr_i = v;
    @(negedge clk_i);
    fast_intr_i   = '0;
    sh_fi_pending = sh_fi_pending | v;
    check_value("fast_intr_o after pulse", 34'(sh_fi_pending & sh_fi_enable),
                34'(fast_intr_o));
  endtask

  task automatic run_stream(input int port);
    for (int i = 0; i < STREAM_LEN; i++) begin
      bus_access(port, "contention", st_we[port][i], st_adr[port][i], st_dat[port][i]);
    end
  endtask

  always @(posedge clk_i) begin
    while (exp_q.size() > 0) begin
      cur_name = name_q.pop_front();
      cur_exp  = exp_q.pop_front();
      cur_act  = act_q.pop_front();
      assert (cur_act == cur_exp) else begin
        $display("[ERROR] %s: expected %h, actual %h", cur_name, cur_exp, cur_act);
        $display("Testbench failed");
        $fatal(1, "Mismatch in %s", cur_name);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  initial begin
    void'($urandom(32'hcba6));
    cycle_cnt           = 0;
    rst_i               = 1'b1;
    drive_req(0, 1'b0, 1'b0, '0, '0);
    drive_req(1, 1'b0, 1'b0, '0, '0);
    xheep_instance_id_i = $urandom();
    boot_select_i       = 1'b1;
    fast_intr_i         = '0;
    cio_gpio_i          = '0;
    sh_exit_valid       = 1'b0;
    sh_exit_value       = '0;
    sh_fi_pending       = '0;
    sh_fi_enable        = '0;
    sh_gpio_out         = '0;
    sh_gpio_en          = '0;
    sh_gpio_intr_en     = '0;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;

    // Reset state of pins and registers
    check_value("reset exit_value_o", '0, 34'(exit_value_o));
    check_value("reset outputs", '0, 34'({exit_valid_o, fast_intr_o, cio_gpio_o}));
    check_value("reset gpio and bus", '0,
                34'({cio_gpio_en_o, intr_gpio_o, sys_ack_o, sys_err_o, spc_ack_o, spc_err_o}));
    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 4; o++) begin
        bus_access(0, "reset read", 1'b0, reg_addr(2'(s), 2'(o)), '0);
      end
    end

    // SoC control
    for (int i = 0; i < 5; i++) begin
      wdat = $urandom();
      bus_access(i % 2, "exit_value write", 1'b1, reg_addr(SOC_CTRL, EXIT_VALUE_OFS), wdat);
      check_value("exit_value_o", 34'(wdat), 34'(exit_value_o));
      bus_access(0, "exit_value read", 1'b0, reg_addr(SOC_CTRL, EXIT_VALUE_OFS), '0);
    end
    bus_access(0, "exit_valid write", 1'b1, reg_addr(SOC_CTRL, EXIT_VALID_OFS), 32'h1);
    check_value("exit_valid_o", 34'(1'b1), 34'(exit_valid_o));
    bus_access(1, "exit_valid read", 1'b0, reg_addr(SOC_CTRL, EXIT_VALID_OFS), '0);

    // GPIO pins, synchronized input and level interrupt
    for (int i = 0; i < 4; i++) begin
      wdat = $urandom();
      bus_access(0, "gpio_out write", 1'b1, reg_addr(GPIO, GPIO_OUT_OFS), wdat);
      check_value("cio_gpio_o", 34'(wdat[7:0]), 34'(cio_gpio_o));
      wdat = $urandom();
      bus_access(1, "gpio_en write", 1'b1, reg_addr(GPIO, GPIO_EN_OFS), wdat);
      check_value("cio_gpio_en_o", 34'(wdat[7:0]), 34'(cio_gpio_en_o));
      bus_access(0, "gpio_out read", 1'b0, reg_addr(GPIO, GPIO_OUT_OFS), '0);
      bus_access(1, "gpio_en read", 1'b0, reg_addr(GPIO, GPIO_EN_OFS), '0);
      wdat = $urandom();
      bus_access(0, "gpio_intr_en write", 1'b1, reg_addr(GPIO, GPIO_INTR_EN_OFS), wdat);
      @(negedge clk_i);
      cio_gpio_i = 8'($urandom());
      repeat (3) @(negedge clk_i);
      check_value("intr_gpio_o", 34'(cio_gpio_i & sh_gpio_intr_en), 34'(intr_gpio_o));
      bus_access(1, "gpio_in read", 1'b0, reg_addr(GPIO, GPIO_IN_OFS), '0);
    end

    // Fast interrupts
    wdat = $urandom();
    bus_access(0, "fi_enable write", 1'b1, reg_addr(FAST_INTR, FI_ENABLE_OFS), wdat);
    bus_access(1, "fi_enable read", 1'b0, reg_addr(FAST_INTR, FI_ENABLE_OFS), '0);
    for (int i = 0; i < 4; i++) begin
      pulse_fast_intr(16'($urandom()));
      bus_access(i % 2, "fi_pending read", 1'b0, reg_addr(FAST_INTR, FI_PENDING_OFS), '0);
      wdat = $urandom();
      bus_access(0, "fi_pending clear", 1'b1, reg_addr(FAST_INTR, FI_PENDING_OFS), wdat);
      check_value("fast_intr_o after clear", 34'(sh_fi_pending & sh_fi_enable),
                  34'(fast_intr_o));
    end

    // Hole in the map
    bus_access(0, "unmapped write", 1'b1, reg_addr(UNMAPPED, 2'd1), $urandom());
    bus_access(1, "unmapped read", 1'b0, reg_addr(UNMAPPED, 2'd2), '0);

    // Both ports at once
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < STREAM_LEN; i++) begin
        st_adr[p][i] = reg_addr(2'($urandom()), 2'($urandom()));
        st_dat[p][i] = $urandom();
        st_we[p][i]  = 1'($urandom());
      end
    end
    done_q.delete();
    fork
      run_stream(0);
      run_stream(1);
    join
    for (int i = 1; i < done_q.size(); i++) begin
      assert (done_q[i] != done_q[i-1]) else begin
        $display("Port %0d completed twice in a row at completion %0d", done_q[i], i);
        $display("Testbench failed");
        $fatal(1, "Round-robin order broken");
      end
    end

    @(posedge clk_i);
    @(negedge clk_i);
    if (exp_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Checks were left unevaluated at the end of the run");
      $display("Testbench failed");
      $fatal(1, "Check queue not drained");
    end
  end

endmodule : tb_ao_peripheral_subsystem

// File: build.f
ao_bus_pkg.sv
ao_periph_pkg.sv
ao_reg_bus_if.sv
ao_bus_arbiter.sv
ao_periph_decoder.sv
ao_soc_ctrl.sv
ao_fast_intr_ctrl.sv
ao_gpio.sv
ao_peripheral_subsystem.sv
tb_ao_peripheral_subsystem.sv

// File: Makefile
# Verilator flow for the always-on peripheral subsystem
# Any variable can be overridden, e.g. make sim TOP=... LOG=...

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_ao_peripheral_subsystem
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
